/* verilog/etx_pkg.sv */
package etx_pkg;

   localparam int PW = 104;                      // Emesh packet width

   typedef logic [PW-1:0] packet_t;              // Full emesh packet
   typedef logic [31:0]   addr_t;                // Dst/src address
   typedef logic [63:0]   beat_t;                // One parallel data beat
   typedef logic [7:0]    frame_t;               // Parallel frame byte

   // Packet field positions
   localparam int WRITE_BIT    = 0;
   localparam int DATAMODE_LSB = 2;              // 2 bits
   localparam int CTRLMODE_LSB = 4;              // 4 bits
   localparam int DSTADDR_LSB  = 8;
   localparam int DATA_LSB     = 40;
   localparam int SRCADDR_LSB  = 72;

   // Frame codes on the parallel frame lane
   localparam frame_t FRAME_IDLE = 8'h00;        // No packet
   localparam frame_t FRAME_HEAD = 8'h3F;        // Beat 0 of a packet
   localparam frame_t FRAME_TAIL = 8'hFF;        // Beat 1 of a packet

   // Destination remap, top 12 bits replaced
   localparam addr_t REMAP_SEL = 32'hFFF0_0000;  // Bits taken from pattern
   localparam addr_t REMAP_PAT = 32'h8E00_0000;  // Replacement value

   // Channel codes
   typedef enum logic [1:0] {
      WR = 2'd0,                                 // Write
      RD = 2'd1,                                 // Read request
      RR = 2'd2                                  // Read response
   } chan_t;

   localparam int FIFO_DEPTH = 4;                // Default channel FIFO depth

endpackage

/* verilog/etx_fifo.sv */
`timescale 1ns/1ps

module etx_fifo import etx_pkg::*; #(
   parameter int DEPTH = FIFO_DEPTH
) (
   input  logic    clk,
   input  logic    rst,
   input  logic    access,                           // Write strobe from outside
   input  packet_t packet,
   output logic    chan_wait,                        // Pushback, equals full
   input  logic    pop,                              // Head taken by arbiter
   output logic    fifo_access,                      // Not empty
   output packet_t fifo_packet                       // Show-ahead head entry
);

   localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CW = $clog2(DEPTH + 1);

   packet_t        mem [DEPTH];                      // Packet storage
   logic [AW-1:0]  wr_ptr;
   logic [AW-1:0]  rd_ptr;
   logic [CW-1:0]  count;                            // Entries held
   logic           push;
   logic           do_pop;

   assign chan_wait   = (count == CW'(DEPTH));
   assign fifo_access = (count != '0);
   assign fifo_packet = mem[rd_ptr];                 // Head visible without a read
   assign push        = access & ~chan_wait;         // Never overwrite when full
   assign do_pop      = pop & fifo_access;

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push)
            wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // Circular wrap
         if (do_pop)
            rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         case ({push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;                 // Idle or push and pop together
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= packet;
   end

   // Sender must honor the pushback level
   a_no_strobe_full : assert property (@(posedge clk) disable iff (rst) access |-> !chan_wait)
      else $error("etx_fifo strobe while full");
   a_no_pop_empty : assert property (@(posedge clk) disable iff (rst) pop |-> fifo_access)
      else $error("etx_fifo pop while empty");

endmodule

/* verilog/etx_arbiter.sv */
`timescale 1ns/1ps

module etx_arbiter import etx_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    wr_access,                        // Write FIFO not empty
   input  packet_t wr_packet,
   input  logic    rd_access,                        // Read request FIFO not empty
   input  packet_t rd_packet,
   input  logic    rr_access,                        // Read response FIFO not empty
   input  packet_t rr_packet,
   input  logic    tx_wr_wait,                       // Partner blocks writes and responses
   input  logic    tx_rd_wait,                       // Partner blocks read requests
   input  logic    remap_wait,                       // Downstream stage full
   output logic    wr_pop,
   output logic    rd_pop,
   output logic    rr_pop,
   output logic    arb_access,
   output packet_t arb_packet,
   output logic    arb_rr                            // Granted packet is a read response
);

   logic    rr_ok;
   logic    rd_ok;
   logic    wr_ok;
   logic    grant_valid;
   chan_t   grant_chan;
   packet_t grant_packet;

   // Partner waits only mask new grants
   assign rr_ok = rr_access & ~tx_wr_wait;
   assign rd_ok = rd_access & ~tx_rd_wait;
   assign wr_ok = wr_access & ~tx_wr_wait;

   always_comb begin
      grant_valid  = 1'b1;
      grant_chan   = RR;
      grant_packet = rr_packet;
      if (rr_ok) begin                               // Responses first
         grant_chan   = RR;
         grant_packet = rr_packet;
      end else if (rd_ok) begin
         grant_chan   = RD;
         grant_packet = rd_packet;
      end else if (wr_ok) begin                      // Writes last
         grant_chan   = WR;
         grant_packet = wr_packet;
      end else begin
         grant_valid  = 1'b0;
      end
   end

   // Pop in the cycle the head is captured
   assign rr_pop = grant_valid & ~remap_wait & (grant_chan == RR);
   assign rd_pop = grant_valid & ~remap_wait & (grant_chan == RD);
   assign wr_pop = grant_valid & ~remap_wait & (grant_chan == WR);

   always_ff @(posedge clk) begin
      if (rst) begin
         arb_access <= 1'b0;
         arb_rr     <= 1'b0;
      end else if (!remap_wait) begin                // Hold while remap stalls
         arb_access <= grant_valid;
         arb_rr     <= grant_valid & (grant_chan == RR);
      end
   end

   always_ff @(posedge clk) begin
      if (!remap_wait)
         arb_packet <= grant_packet;
   end

   a_one_pop : assert property (@(posedge clk) disable iff (rst) $onehot0({wr_pop, rd_pop, rr_pop}))
      else $error("etx_arbiter popped more than one channel");

endmodule

/* verilog/etx_remap.sv */
`timescale 1ns/1ps

module etx_remap import etx_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    remap_en,                         // Level enable for address remap
   input  logic    arb_access,
   input  packet_t arb_packet,
   input  logic    arb_rr,                           // Read responses bypass remap
   input  logic    prot_wait,                        // Protocol busy with beat 0
   output logic    remap_wait,
   output logic    remap_access,
   output packet_t remap_packet
);

   addr_t   dst_in;
   addr_t   dst_out;
   packet_t packet_next;

   assign dst_in  = arb_packet[DSTADDR_LSB +: $bits(addr_t)];
   assign dst_out = (remap_en && !arb_rr) ?
                    ((dst_in & ~REMAP_SEL) | (REMAP_PAT & REMAP_SEL)) : dst_in;

   always_comb begin
      packet_next = arb_packet;
      packet_next[DSTADDR_LSB +: $bits(addr_t)] = dst_out;  // Only dstaddr can change
   end

   assign remap_wait = remap_access & prot_wait;     // Stall only when holding a packet

   always_ff @(posedge clk) begin
      if (rst)
         remap_access <= 1'b0;
      else if (!remap_wait)
         remap_access <= arb_access;
   end

   always_ff @(posedge clk) begin
      if (!remap_wait)
         remap_packet <= packet_next;
   end

endmodule

/* verilog/etx_protocol.sv */
`timescale 1ns/1ps

module etx_protocol import etx_pkg::*; (
   input  logic    clk,
   input  logic    rst,
   input  logic    remap_access,
   input  packet_t remap_packet,
   output logic    prot_wait,                        // High while beat 0 is out
   output frame_t  tx_frame_par,
   output beat_t   tx_data_par
);

   typedef enum logic [1:0] {
      IDLE,                                          // Nothing on the lanes
      HEAD,                                          // Beat 0 on the lanes
      TAIL                                           // Beat 1 on the lanes
   } state_t;

   state_t state;
   beat_t  head_beat;
   beat_t  tail_beat;                                // Beat 1 kept for next cycle
   logic   take;

   // Beat 0 layout: control byte, dstaddr, three zero bytes
   assign head_beat = {remap_packet[CTRLMODE_LSB +: 4],
                       remap_packet[DATAMODE_LSB +: 2],
                       remap_packet[WRITE_BIT],
                       1'b0,
                       remap_packet[DSTADDR_LSB +: $bits(addr_t)],
                       24'h0};

   assign prot_wait = (state == HEAD);
   assign take      = remap_access & (state != HEAD);  // One packet per two cycles

   always_ff @(posedge clk) begin
      if (rst) begin
         state        <= IDLE;
         tx_frame_par <= FRAME_IDLE;
         tx_data_par  <= '0;
      end else if (take) begin
         state        <= HEAD;
         tx_frame_par <= FRAME_HEAD;
         tx_data_par  <= head_beat;
      end else if (state == HEAD) begin
         state        <= TAIL;
         tx_frame_par <= FRAME_TAIL;
         tx_data_par  <= tail_beat;
      end else begin
         state        <= IDLE;
         tx_frame_par <= FRAME_IDLE;
         tx_data_par  <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (take)
         tail_beat <= {remap_packet[DATA_LSB +: 32], remap_packet[SRCADDR_LSB +: 32]};
   end

   a_tail_follows : assert property (@(posedge clk) disable iff (rst)
                                     tx_frame_par == FRAME_HEAD |=> tx_frame_par == FRAME_TAIL)
      else $error("etx_protocol beat 1 missing after beat 0");

endmodule

/* verilog/etx.sv */
`timescale 1ns/1ps

module etx import etx_pkg::*; (
   input  logic    tx_lclk_div4,                     // Parallel clock
   input  logic    rst,
   input  logic    remap_en,
   input  logic    txwr_access,                      // Write channel
   input  packet_t txwr_packet,
   output logic    txwr_wait,
   input  logic    txrd_access,                      // Read request channel
   input  packet_t txrd_packet,
   output logic    txrd_wait,
   input  logic    txrr_access,                      // Read response channel
   input  packet_t txrr_packet,
   output logic    txrr_wait,
   input  logic    tx_wr_wait,                       // Partner wait levels
   input  logic    tx_rd_wait,
   output frame_t  tx_frame_par,
   output beat_t   tx_data_par
);

   logic    txwr_fifo_access;
   packet_t txwr_fifo_packet;
   logic    txwr_pop;
   logic    txrd_fifo_access;
   packet_t txrd_fifo_packet;
   logic    txrd_pop;
   logic    txrr_fifo_access;
   packet_t txrr_fifo_packet;
   logic    txrr_pop;
   logic    arb_access;
   packet_t arb_packet;
   logic    arb_rr;
   logic    remap_wait;
   logic    remap_access;
   packet_t remap_packet;
   logic    prot_wait;

   etx_fifo #(.DEPTH(FIFO_DEPTH)) txwr_fifo (
      .clk (tx_lclk_div4), .rst (rst),
      .access (txwr_access), .packet (txwr_packet), .chan_wait (txwr_wait),
      .pop (txwr_pop), .fifo_access (txwr_fifo_access), .fifo_packet (txwr_fifo_packet));

   etx_fifo #(.DEPTH(FIFO_DEPTH)) txrd_fifo (
      .clk (tx_lclk_div4), .rst (rst),
      .access (txrd_access), .packet (txrd_packet), .chan_wait (txrd_wait),
      .pop (txrd_pop), .fifo_access (txrd_fifo_access), .fifo_packet (txrd_fifo_packet));

   etx_fifo #(.DEPTH(FIFO_DEPTH)) txrr_fifo (
      .clk (tx_lclk_div4), .rst (rst),
      .access (txrr_access), .packet (txrr_packet), .chan_wait (txrr_wait),
      .pop (txrr_pop), .fifo_access (txrr_fifo_access), .fifo_packet (txrr_fifo_packet));

   etx_arbiter etx_arbiter (
      .clk (tx_lclk_div4), .rst (rst),
      .wr_access (txwr_fifo_access), .wr_packet (txwr_fifo_packet),
      .rd_access (txrd_fifo_access), .rd_packet (txrd_fifo_packet),
      .rr_access (txrr_fifo_access), .rr_packet (txrr_fifo_packet),
      .tx_wr_wait (tx_wr_wait), .tx_rd_wait (tx_rd_wait), .remap_wait (remap_wait),
      .wr_pop (txwr_pop), .rd_pop (txrd_pop), .rr_pop (txrr_pop),
      .arb_access (arb_access), .arb_packet (arb_packet), .arb_rr (arb_rr));

   etx_remap etx_remap (
      .clk (tx_lclk_div4), .rst (rst), .remap_en (remap_en),
      .arb_access (arb_access), .arb_packet (arb_packet), .arb_rr (arb_rr),
      .prot_wait (prot_wait), .remap_wait (remap_wait),
      .remap_access (remap_access), .remap_packet (remap_packet));

   etx_protocol etx_protocol (
      .clk (tx_lclk_div4), .rst (rst),
      .remap_access (remap_access), .remap_packet (remap_packet),
      .prot_wait (prot_wait),
      .tx_frame_par (tx_frame_par), .tx_data_par (tx_data_par));

endmodule

/* testbench/etx_tb.sv */
`timescale 1ns/1ps

module etx_tb import etx_pkg::*; ();

   logic    clk = 1'b0;
   logic    rst;
   logic    remap_en;
   logic    txwr_access, txrd_access, txrr_access;
   packet_t txwr_packet, txrd_packet, txrr_packet;
   logic    txwr_wait, txrd_wait, txrr_wait;
   logic    tx_wr_wait, tx_rd_wait;
   frame_t  tx_frame_par;
   beat_t   tx_data_par;

   string       ph_q[$];                             // Case table from file
   chan_t       ch_q[$];
   packet_t     pk_q[$];
   int          gap_q[$];
   packet_t     exp_q[$];                            // Sent, not yet delivered
   chan_t       exp_ch_q[$];
   string       exp_name_q[$];
   logic [31:0] rng = 32'hcc6884ee;
   int          cycles = 0;
   int          limit = 0;                           // 0 until cases are loaded
   int          phase_sent = 0;
   int          last_rank = 0;
   logic        strobe_live = 1'b0;
   chan_t       strobe_ch = WR;
   logic        remap_on = 1'b0;
   logic        rd_blocked = 1'b0;                   // No read request may leave
   logic        order_check = 1'b0;                  // RR, then RD, then WR
   logic        tail_due = 1'b0;
   beat_t       head_data;

   etx dut (
      .tx_lclk_div4 (clk), .rst (rst), .remap_en (remap_en),
      .txwr_access (txwr_access), .txwr_packet (txwr_packet), .txwr_wait (txwr_wait),
      .txrd_access (txrd_access), .txrd_packet (txrd_packet), .txrd_wait (txrd_wait),
      .txrr_access (txrr_access), .txrr_packet (txrr_packet), .txrr_wait (txrr_wait),
      .tx_wr_wait (tx_wr_wait), .tx_rd_wait (tx_rd_wait),
      .tx_frame_par (tx_frame_par), .tx_data_par (tx_data_par));

   always #4 clk = ~clk;                             // 8 ns period

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Expected dstaddr after the remap rule
   function automatic packet_t remapped(input packet_t p, input chan_t ch, input logic en);
      packet_t q;
      q = p;
      if (en && ch != RR)
         for (int b = 0; b < 32; b++)
            if (REMAP_SEL[b])
               q[8 + b] = REMAP_PAT[b];              // Selected bit taken from pattern
      return q;
   endfunction

   function automatic beat_t head_of(input packet_t p);
      return {p[7:4], p[3:2], p[0], 1'b0, p[39:8], 24'h0};  // Control byte, dstaddr, zeros
   endfunction

   function automatic beat_t tail_of(input packet_t p);
      return {p[71:40], p[103:72]};                  // Data over srcaddr
   endfunction

   function automatic packet_t unpack_beats(input beat_t h, input beat_t t);
      packet_t p;
      p = '0;
      p[7:4]    = h[63:60];
      p[3:2]    = h[59:58];
      p[0]      = h[57];
      p[39:8]   = h[55:24];
      p[71:40]  = t[63:32];
      p[103:72] = t[31:0];
      return p;
   endfunction

   function automatic logic chan_full(input chan_t ch);
      case (ch)
         WR:      return txwr_wait;
         RD:      return txrd_wait;
         default: return txrr_wait;
      endcase
   endfunction

   function automatic int count_pending(input chan_t ch);
      int n;
      n = 0;
      foreach (exp_ch_q[i])
         if (exp_ch_q[i] == ch)
            n++;
      return n;
   endfunction

   task automatic report_failure(input string msg);
      $display("%s", msg);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped at first failure");
   endtask

   task automatic check_frame(input string name, input frame_t exp, input frame_t act);
      if (act !== exp)
         report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_beat(input string name, input beat_t exp, input beat_t act);
      if (act !== exp)
         report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_packet(input string name, input packet_t exp, input packet_t act);
      if (act !== exp)
         report_failure($sformatf("Error: %s expected %h actual %h", name, exp, act));
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
         report_failure($sformatf("Error: %s expected %b actual %b", name, exp, act));
   endtask

   task automatic drop_strobes();
      txwr_access <= 1'b0;
      txrd_access <= 1'b0;
      txrr_access <= 1'b0;
      strobe_live = 1'b0;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(posedge clk);
         drop_strobes();
      end
   endtask

   task automatic send_packet(input chan_t ch, input packet_t pkt, input string name);
      if (strobe_live && strobe_ch == ch)            // Let the last push land first
         idle_cycles(1);
      @(negedge clk);
      while (chan_full(ch)) begin
         idle_cycles(1);
         @(negedge clk);
      end
      @(posedge clk);
      drop_strobes();
      case (ch)
         WR: begin
            txwr_access <= 1'b1;
            txwr_packet <= pkt;
         end
         RD: begin
            txrd_access <= 1'b1;
            txrd_packet <= pkt;
         end
         default: begin
            txrr_access <= 1'b1;
            txrr_packet <= pkt;
         end
      endcase
      strobe_live = 1'b1;
      strobe_ch   = ch;
      phase_sent++;
      exp_q.push_back(remapped(pkt, ch, remap_on));
      exp_ch_q.push_back(ch);
      exp_name_q.push_back(name);
   endtask

   // srcaddr finds the channel, then the oldest entry of that channel must match
   task automatic match_delivery(input beat_t h, input beat_t t);
      packet_t got;
      int      hit;
      int      first;
      chan_t   ch;
      int      rank;
      got   = unpack_beats(h, t);
      hit   = -1;
      first = -1;
      foreach (exp_q[i])
         if (hit < 0 && exp_q[i][103:72] == got[103:72])
            hit = i;
      if (hit < 0)
         report_failure($sformatf("Packet with srcaddr %h arrived twice or was never sent",
                                  got[103:72]));
      else begin
         ch   = exp_ch_q[hit];
         rank = 2 - int'(ch);                        // RR=0, RD=1, WR=2
         foreach (exp_ch_q[i])
            if (first < 0 && exp_ch_q[i] == ch)
               first = i;
         if (rd_blocked && ch == RD)
            report_failure("A read request left the DUT while tx_rd_wait was high");
         else if (order_check && rank < last_rank)
            report_failure("Queued packets left out of priority order after the waits dropped");
         else begin
            check_beat({exp_name_q[first], " head beat"}, head_of(exp_q[first]), h);
            check_beat({exp_name_q[first], " tail beat"}, tail_of(exp_q[first]), t);
            check_packet({exp_name_q[first], " packet"}, exp_q[first], got);
            last_rank = rank;
            exp_q.delete(first);
            exp_ch_q.delete(first);
            exp_name_q.delete(first);
         end
      end
   endtask

   task automatic load_cases();
      int          fd;
      int          n;
      string       line;
      string       ph;
      string       cs;
      logic [31:0] w, dm, cm, dst, dat, src;
      int          gap;
      packet_t     pkt;
      fd = $fopen("testbench/etx_cases.txt", "r");
      if (fd == 0)
         report_failure("Case file testbench/etx_cases.txt could not be opened");
      while (fd != 0 && !$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (line.len() > 1 && line.getc(0) != "#") begin   // Skip comments and blanks
            n = $sscanf(line, "%s %s %h %h %h %h %h %h %d", ph, cs, w, dm, cm, dst, dat, src, gap);
            if (n != 9 || (cs != "wr" && cs != "rd" && cs != "rr"))
               report_failure({"Case file line could not be parsed: ", line});
            pkt = '0;
            pkt[0]      = w[0];
            pkt[3:2]    = dm[1:0];
            pkt[7:4]    = cm[3:0];
            pkt[39:8]   = dst;
            pkt[71:40]  = dat;
            pkt[103:72] = src;
            if (ph == "burst") begin
               rng = xorshift(rng);
               gap = gap + int'(rng[1:0]);           // Random idle gap 0 to 3
            end
            ph_q.push_back(ph);
            ch_q.push_back(cs == "wr" ? WR : (cs == "rd" ? RD : RR));
            pk_q.push_back(pkt);
            gap_q.push_back(gap);
         end
      end
      if (fd != 0)
         $fclose(fd);
   endtask

   task automatic drain_pipeline();
      idle_cycles(1);
      while (exp_q.size() != 0)
         @(negedge clk);
      idle_cycles(4);
   endtask

   task automatic start_phase(input string name);
      @(posedge clk);
      drop_strobes();
      remap_on    = (name == "remap_on") || (name == "burst");
      remap_en   <= remap_on;
      tx_wr_wait <= (name == "block_both");
      tx_rd_wait <= (name == "block_both") || (name == "block_rd");
      rd_blocked  = (name == "block_rd");
      phase_sent  = 0;
      last_rank   = 0;
   endtask

   task automatic finish_phase(input string name);
      idle_cycles(3);
      if (name == "block_both") begin
         @(negedge clk);
         check_bit("block_both txwr_wait", 1'b1, txwr_wait);     // Every FIFO full
         check_bit("block_both txrd_wait", 1'b1, txrd_wait);
         check_bit("block_both txrr_wait", 1'b1, txrr_wait);
         if (exp_q.size() != phase_sent)
            report_failure("Packets left the DUT while both partner waits were high");
         @(posedge clk);
         tx_wr_wait <= 1'b0;
         tx_rd_wait <= 1'b0;
         order_check = 1'b1;
      end else if (name == "block_rd") begin
         while (count_pending(WR) != 0)              // Writes pass despite the rd block
            @(negedge clk);
         idle_cycles(8);
         tx_rd_wait <= 1'b0;
         rd_blocked  = 1'b0;
      end
      drain_pipeline();
      order_check = 1'b0;
   endtask

   always @(negedge clk) begin
      if (!rst) begin
         if ((txwr_access && txwr_wait) || (txrd_access && txrd_wait) ||
             (txrr_access && txrr_wait))
            report_failure("The testbench strobed a channel whose wait was high");
         else if (tail_due) begin
            check_frame("frame after head", FRAME_TAIL, tx_frame_par);
            tail_due = 1'b0;
            match_delivery(head_data, tx_data_par);
         end else if (tx_frame_par == FRAME_HEAD) begin
            head_data = tx_data_par;                 // Pair with next beat
            tail_due  = 1'b1;
         end else begin
            check_frame("idle frame", FRAME_IDLE, tx_frame_par);
            check_beat("idle data", '0, tx_data_par);
         end
      end
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (limit > 0 && cycles > limit)
         report_failure($sformatf("Timeout after %0d cycles with packets still undelivered",
                                  cycles));
   end

   initial begin
      int    gap_sum;
      string cur;
      rst         = 1'b1;
      remap_en    = 1'b0;
      txwr_access = 1'b0;
      txrd_access = 1'b0;
      txrr_access = 1'b0;
      txwr_packet = '0;
      txrd_packet = '0;
      txrr_packet = '0;
      tx_wr_wait  = 1'b0;
      tx_rd_wait  = 1'b0;
      load_cases();
      gap_sum = 0;
      foreach (gap_q[k])
         gap_sum += gap_q[k];
      limit = 20 * pk_q.size() + gap_sum + 200;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(negedge clk);
      check_frame("reset frame", FRAME_IDLE, tx_frame_par);
      check_beat("reset data", '0, tx_data_par);
      check_bit("reset txwr_wait", 1'b0, txwr_wait);
      check_bit("reset txrd_wait", 1'b0, txrd_wait);
      check_bit("reset txrr_wait", 1'b0, txrr_wait);
      cur = "";
      for (int i = 0; i < pk_q.size(); i++) begin
         if (ph_q[i] != cur) begin                   // Phase boundary
            if (cur != "")
               finish_phase(cur);
            cur = ph_q[i];
            start_phase(cur);
         end
         send_packet(ch_q[i], pk_q[i], $sformatf("%s case %0d", cur, i));
         idle_cycles(gap_q[i]);
      end
      if (cur != "")
         finish_phase(cur);
      if (exp_q.size() == 0 && pk_q.size() != 0) begin
         $display("ALL TESTS PASSED");
         $finish;
      end else
         report_failure("No cases were run or packets were never delivered");
   end

endmodule

/* testbench/etx_cases.txt */
# phase chan write datamode ctrlmode dstaddr data srcaddr gap
# chan is wr, rd or rr; packet fields in hex; gap is idle cycles in decimal
single     wr 1 2 5 12345678 cafef00d 00000001 0
remap_on   wr 1 2 0 12345678 11111111 00000002 0
remap_on   rd 0 2 3 81000040 00000000 00000003 0
remap_on   rr 1 2 0 fff00010 22222222 00000004 2
remap_off  wr 1 1 3 abcdef01 33333333 00000005 0
remap_off  rd 0 2 0 81000044 00000000 00000006 0
remap_off  rr 1 2 9 8e012340 44444444 00000007 2
burst      wr 1 2 0 20000000 55555555 00000010 0
burst      rd 0 2 1 20000004 00000000 00000011 0
burst      rr 1 2 0 20000008 66666666 00000012 0
burst      wr 1 3 2 2000000c 77777777 00000013 0
burst      wr 1 0 0 20000010 88888888 00000014 0
burst      rr 1 2 f 20000014 99999999 00000015 0
block_both wr 1 2 0 30000000 a0000001 00000020 0
block_both rd 0 2 0 30000004 00000000 00000021 0
block_both rr 1 2 0 30000008 a0000002 00000022 0
block_both wr 1 2 0 3000000c a0000003 00000023 0
block_both rd 0 2 0 30000010 00000000 00000024 0
block_both rr 1 2 0 30000014 a0000004 00000025 0
block_both wr 1 2 0 30000018 a0000005 00000026 0
block_both rd 0 2 0 3000001c 00000000 00000027 0
block_both rr 1 2 0 30000020 a0000006 00000028 0
block_both wr 1 2 0 30000024 a0000007 00000029 0
block_both rd 0 2 0 30000028 00000000 0000002a 0
block_both rr 1 2 0 3000002c a0000008 0000002b 0
block_rd   wr 1 2 0 40000000 b0000001 00000030 0
block_rd   rd 0 2 0 40000004 00000000 00000031 0
block_rd   wr 1 2 0 40000008 b0000002 00000032 0
block_rd   rd 0 2 0 4000000c 00000000 00000033 0

/* compile.f */
verilog/etx_pkg.sv
verilog/etx_fifo.sv
verilog/etx_arbiter.sv
verilog/etx_remap.sv
verilog/etx_protocol.sv
verilog/etx.sv
testbench/etx_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = etx_tb
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: compile
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
